// File: filelist.f
riscv_mem_pkg.sv
riscv_noicache_core.sv
riscv_dmem_port.sv
riscv_biu_wb.sv
riscv_mem_top.sv
tb_riscv_mem.sv

// File: Makefile
# Verilator build and run of the memory front end testbench

VERILATOR ?= verilator
SEED      ?= 51116
TIMEOUT   ?= 500
OBJ_DIR   ?= obj_dir
TOP       := tb_riscv_mem

VFLAGS := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) \
          -GSEED=$(SEED) -GTIMEOUT=$(TIMEOUT)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench (SEED, TIMEOUT, VERILATOR)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f filelist.f
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_riscv_mem.sv
`timescale 1ns/1ps
//////////////////////////////
// memory front end testbench
// random fetch, flush, stall and load/store traffic
//////////////////////////////
module tb_riscv_mem #(
  parameter logic [31:0] SEED    = 32'hc7ac,
  parameter int          TIMEOUT = 500,
  parameter int          CYCLES  = 4000
);
  import riscv_mem_pkg::*;

  localparam addr_t ERR_BASE = 32'hF000_0000;
  localparam addr_t DAT_BASE = 32'h8000_0000;

  logic clk = 1'b0;
  logic rstn;
  logic if_stall, if_flush, if_stall_nxt_pc, if_parcel_valid, if_parcel_misaligned;
  addr_t if_nxt_pc, if_parcel_pc, mem_adr, wb_adr;
  word_t if_parcel, mem_d, mem_q, wb_dat_o, wb_dat_i;
  logic mem_req, mem_we, mem_rdy, mem_ack, mem_err;
  size_t mem_size;
  logic wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [3:0] wb_sel;

  // wishbone slave image and reference image
  word_t slv_mem [addr_t];
  word_t mdl_mem [addr_t];
  int    write_cnt;
  int    ws_left;
  logic [31:0] ws_rng;
  logic [31:0] cpu_rng;

  // fetch model, pcs still owed a parcel
  addr_t exp_pc [$];
  addr_t pc;
  int    idle_cnt, parcel_cnt;
  logic  rand_on, hold_flush;

  // data op in flight
  logic  dm_busy, op_we, op_err;
  size_t op_size;
  addr_t op_adr;
  word_t op_dat;
  int    dm_wait, wcnt0;

  riscv_mem_top #(.XLEN(32), .PLEN(32)) dut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // power-up contents, every address bit counts
  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t mdl_rd(input addr_t a);
    addr_t w;
    w = a & ~32'h3;
    return mdl_mem.exists(w) ? mdl_mem[w] : fill_word(w);
  endfunction

  task automatic chk(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error: %s expected %h got %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  //////////////////////////////
  // wishbone slave, 0..3 waits
  //////////////////////////////
  always @(posedge clk) begin : slave
    word_t w;
    addr_t a;
    if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
      if (ws_left == 0) begin
        a = wb_adr & ~32'h3;
        if (wb_adr >= ERR_BASE) begin
          wb_err <= 1'b1;
        end else begin
          w = slv_mem.exists(a) ? slv_mem[a] : fill_word(a);
          if (wb_we) begin
            for (int i = 0; i < 4; i++)
              if (wb_sel[i]) w[8*i +: 8] = wb_dat_o[8*i +: 8];
            slv_mem[a] = w;
            write_cnt  <= write_cnt + 1;
          end
          wb_dat_i <= w;
          wb_ack   <= 1'b1;
        end
      end else begin
        ws_left <= ws_left - 1;
      end
    end else begin
      wb_ack  <= 1'b0;
      wb_err  <= 1'b0;
      ws_rng = xorshift(ws_rng);
      ws_left <= ws_rng % 4;
    end
  end

  task automatic flush_to(input addr_t npc);
    pc = npc;
    exp_pc.delete();
    if_flush  <= 1'b1;
    if_nxt_pc <= npc;
  endtask

  task automatic start_data(input logic we, input size_t sz, input addr_t a, input word_t d);
    mem_req  <= 1'b1;
    mem_we   <= we;
    mem_size <= sz;
    mem_adr  <= a;
    mem_d    <= d;
    op_we = we;
    op_size = sz;
    op_adr = a;
    op_dat = d;
    op_err = (sz == SIZE_HALF && a[0]) || (sz == SIZE_WORD && a[1:0] != 2'b00) ||
             (a >= ERR_BASE);
    dm_busy = 1'b1;
    dm_wait = 0;
    wcnt0 = write_cnt;
  endtask

  // compare or apply a finished data op against the reference image
  task automatic finish_data();
    word_t base, expv, mask;
    int n;
    chk("mem_err", op_err, mem_err);
    chk("mem_ack", !op_err, mem_ack);
    n = 1 << op_size;
    base = mdl_rd(op_adr);
    expv = '0;
    mask = (n == 4) ? 32'hffff_ffff : ((32'h1 << (8 * n)) - 1);
    if (op_err) begin
      chk("wb write count", wcnt0, write_cnt);
    end else if (op_we) begin
      for (int i = 0; i < n; i++)
        base[8*(op_adr[1:0]+i) +: 8] = op_dat[8*i +: 8];
      mdl_mem[op_adr & ~32'h3] = base;
    end else begin
      for (int i = 0; i < n; i++)
        expv[8*i +: 8] = base[8*(op_adr[1:0]+i) +: 8];
      chk("mem_q", expv & mask, mem_q & mask);
    end
    dm_busy = 1'b0;
  endtask

  //////////////////////////////
  // one clock of cpu model
  //////////////////////////////
  task automatic run_cycle();
    logic [31:0] r, r2;
    addr_t a;
    @(posedge clk);
    // pre-edge values, all tb drives are non-blocking
    if (if_parcel_valid) begin
      if (exp_pc.size() == 0) fail_run("parcel appeared with no fetch owed");
      chk("if_parcel_pc", exp_pc[0], if_parcel_pc);
      chk("if_parcel", mdl_rd(exp_pc[0]), if_parcel);
      chk("if_parcel_misaligned", |exp_pc[0][1:0], if_parcel_misaligned);
      void'(exp_pc.pop_front());
      parcel_cnt++;
      idle_cnt = 0;
    end else if (exp_pc.size() != 0) begin
      idle_cnt++;
      if (idle_cnt > TIMEOUT) fail_run("fetch made no progress before timeout");
    end
    if (!if_stall_nxt_pc && !if_flush) begin
      // error region fetches never return a parcel
      if (pc < ERR_BASE) exp_pc.push_back(pc);
      pc = pc + 4;
    end
    // port busy from the cycle after acceptance until its ack or err
    chk("mem_rdy", !(dm_busy && !mem_req && !mem_ack && !mem_err), mem_rdy);
    if (dm_busy && !mem_req) begin
      dm_wait++;
      if (mem_ack || mem_err) finish_data();
      else if (dm_wait > TIMEOUT) fail_run("load/store got no answer before timeout");
    end
    mem_req  <= 1'b0;
    if_stall <= 1'b0;
    if_flush <= 1'b0;
    if (hold_flush) begin
      flush_to(pc);
    end else if (rand_on) begin
      cpu_rng = xorshift(cpu_rng);
      r = cpu_rng;
      if (r[4:0] == 5'd0) begin
        case (r[7:5])
          3'd0:    flush_to(ERR_BASE + {r[19:10], 2'b00});
          3'd1:    flush_to({20'b0, r[21:12], r[23:22]});
          default: flush_to({20'b0, r[21:12], 2'b00});
        endcase
      end
      if_stall <= (r[9:8] == 2'd0);
      if (!dm_busy && r[14:12] == 3'd0) begin
        cpu_rng = xorshift(cpu_rng);
        r2 = cpu_rng;
        if (r2[7:5] == 3'd0) a = ERR_BASE | r2[15:8];
        else if (r2[4]) a = DAT_BASE | r2[15:8];
        else a = {20'b0, r2[19:8]};
        // code region only loaded, stores stay in data or error region
        start_data(r2[0] & (a >= DAT_BASE), (r2[2:1] == 2'd3) ? SIZE_WORD : r2[2:1],
                   a, xorshift(r2));
      end
    end
    if_nxt_pc <= pc;
  endtask

  task automatic wait_data_idle();
    int n;
    n = 0;
    while (dm_busy) begin
      run_cycle();
      n++;
      if (n > TIMEOUT) fail_run("data port stayed busy past timeout");
    end
  endtask

  initial begin
    int n;
    int k;
    rstn = 1'b0;
    if_stall = 1'b0;
    if_flush = 1'b0;
    if_nxt_pc = '0;
    mem_req = 1'b0;
    mem_we = 1'b0;
    mem_size = SIZE_WORD;
    mem_adr = '0;
    mem_d = '0;
    wb_dat_i = '0;
    wb_ack = 1'b0;
    wb_err = 1'b0;
    write_cnt = 0;
    ws_left = 0;
    ws_rng = xorshift(SEED ^ 32'h0000_5a5a);
    cpu_rng = SEED;
    pc = '0;
    idle_cnt = 0;
    parcel_cnt = 0;
    rand_on = 1'b1;
    hold_flush = 1'b0;
    dm_busy = 1'b0;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    for (int c = 0; c < CYCLES; c++) run_cycle();

    // store into data region, then fetch and load it back
    rand_on = 1'b0;
    wait_data_idle();
    hold_flush = 1'b1;
    run_cycle();
    start_data(1'b1, SIZE_WORD, DAT_BASE + 32'h40, 32'h1357_9bdf);
    wait_data_idle();
    hold_flush = 1'b0;
    flush_to(DAT_BASE + 32'h40);
    n = parcel_cnt;
    k = 0;
    while (parcel_cnt == n) begin
      run_cycle();
      k++;
      if (k > TIMEOUT) fail_run("no parcel after flush before timeout");
    end
    run_cycle();
    start_data(1'b0, SIZE_WORD, DAT_BASE + 32'h40, '0);
    wait_data_idle();
    repeat (20) run_cycle();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: riscv_mem_top.sv
`timescale 1ns/1ps
//////////////////////////////
// memory front end top
//////////////////////////////
module riscv_mem_top #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic                 clk,
  input  logic                 rstn,

  // fetch
  input  logic                 if_stall,
  input  logic                 if_flush,
  input  riscv_mem_pkg::addr_t if_nxt_pc,
  output logic                 if_stall_nxt_pc,
  output riscv_mem_pkg::addr_t if_parcel_pc,
  output riscv_mem_pkg::word_t if_parcel,
  output logic                 if_parcel_valid,
  output logic                 if_parcel_misaligned,

  // load/store
  input  logic                 mem_req,
  input  logic                 mem_we,
  input  riscv_mem_pkg::size_t mem_size,
  input  riscv_mem_pkg::addr_t mem_adr,
  input  riscv_mem_pkg::word_t mem_d,
  output logic                 mem_rdy,
  output riscv_mem_pkg::word_t mem_q,
  output logic                 mem_ack,
  output logic                 mem_err,

  // wishbone
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output riscv_mem_pkg::addr_t wb_adr,
  output logic [3:0]           wb_sel,
  output riscv_mem_pkg::word_t wb_dat_o,
  input  riscv_mem_pkg::word_t wb_dat_i,
  input  logic                 wb_ack,
  input  logic                 wb_err
);
  import riscv_mem_pkg::*;

  biu_req_t if_biu_req;
  biu_rsp_t if_biu_rsp;
  biu_req_t dm_biu_req;
  biu_rsp_t dm_biu_rsp;

  riscv_noicache_core #(.XLEN(XLEN), .PLEN(PLEN)) u_fetch (
    .clk                  (clk),
    .rstn                 (rstn),
    .if_stall             (if_stall),
    .if_flush             (if_flush),
    .if_nxt_pc            (if_nxt_pc),
    .if_stall_nxt_pc      (if_stall_nxt_pc),
    .if_parcel_pc         (if_parcel_pc),
    .if_parcel            (if_parcel),
    .if_parcel_valid      (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .if_biu_req           (if_biu_req),
    .if_biu_rsp           (if_biu_rsp)
  );

  riscv_dmem_port #(.XLEN(XLEN), .PLEN(PLEN)) u_dmem (
    .clk        (clk),
    .rstn       (rstn),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_size   (mem_size),
    .mem_adr    (mem_adr),
    .mem_d      (mem_d),
    .mem_rdy    (mem_rdy),
    .mem_q      (mem_q),
    .mem_ack    (mem_ack),
    .mem_err    (mem_err),
    .dm_biu_req (dm_biu_req),
    .dm_biu_rsp (dm_biu_rsp)
  );

  riscv_biu_wb #(.XLEN(XLEN), .PLEN(PLEN)) u_biu (
    .clk        (clk),
    .rstn       (rstn),
    .if_biu_req (if_biu_req),
    .if_biu_rsp (if_biu_rsp),
    .dm_biu_req (dm_biu_req),
    .dm_biu_rsp (dm_biu_rsp),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel),
    .wb_dat_o   (wb_dat_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err)
  );

endmodule

// File: riscv_biu_wb.sv
`timescale 1ns/1ps
//////////////////////////////
// wishbone classic biu
// fetch/data arbitration, data side wins
//////////////////////////////
module riscv_biu_wb #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic                    clk,
  input  logic                    rstn,

  // requesters
  input  riscv_mem_pkg::biu_req_t if_biu_req,
  output riscv_mem_pkg::biu_rsp_t if_biu_rsp,
  input  riscv_mem_pkg::biu_req_t dm_biu_req,
  output riscv_mem_pkg::biu_rsp_t dm_biu_rsp,

  // wishbone master
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output riscv_mem_pkg::addr_t    wb_adr,
  output logic [3:0]              wb_sel,
  output riscv_mem_pkg::word_t    wb_dat_o,
  input  riscv_mem_pkg::word_t    wb_dat_i,
  input  logic                    wb_ack,
  input  logic                    wb_err
);
  import riscv_mem_pkg::*;

  localparam int OFS_BITS = $clog2(XLEN/8);

  arb_state_t state;
  logic       grant_dm;
  logic       grant_if;
  logic       done;
  biu_req_t   sel_req;
  logic [3:0] sel_nxt;
  addr_t      lat_adr;

  //////////////////////////////
  // arbitration
  //////////////////////////////

  assign grant_dm = (state == ARB_IDLE) & dm_biu_req.stb;
  assign grant_if = (state == ARB_IDLE) & if_biu_req.stb & ~dm_biu_req.stb;
  assign sel_req  = dm_biu_req.stb ? dm_biu_req : if_biu_req;
  assign done     = wb_ack | wb_err;

  // byte enables from size and low address bits
  always_comb begin
    case (sel_req.size)
      SIZE_BYTE: sel_nxt = 4'b0001 << sel_req.adr[OFS_BITS-1:0];
      SIZE_HALF: sel_nxt = 4'b0011 << {sel_req.adr[OFS_BITS-1:1], 1'b0};
      default:   sel_nxt = 4'b1111;
    endcase
  end

  // cyc/stb rise the cycle after the grant, drop after ack or err
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= ARB_IDLE;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (grant_dm || grant_if) begin
            state  <= grant_dm ? ARB_DATA : ARB_FETCH;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
          end
        end
        ARB_FETCH, ARB_DATA: begin
          // back through idle so cyc stays low at least one cycle
          if (done) begin
            state  <= ARB_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // granted request, held for the whole cycle
  always_ff @(posedge clk) begin
    if (grant_dm || grant_if) begin
      lat_adr  <= sel_req.adr;
      wb_we    <= sel_req.we;
      wb_sel   <= sel_nxt;
      // store data into its byte lanes
      wb_dat_o <= sel_req.di << {sel_req.adr[OFS_BITS-1:0], 3'b000};
    end
  end

  // word address on the bus, lanes picked by wb_sel
  assign wb_adr = addr_t'({lat_adr[PLEN-1:OFS_BITS], {OFS_BITS{1'b0}}});

  //////////////////////////////
  // responses
  //////////////////////////////

  assign if_biu_rsp.stb_ack = grant_if;
  assign if_biu_rsp.ack     = (state == ARB_FETCH) & wb_ack;
  assign if_biu_rsp.err     = (state == ARB_FETCH) & wb_err;
  assign if_biu_rsp.adro    = lat_adr;
  assign if_biu_rsp.dout    = wb_dat_i;

  assign dm_biu_rsp.stb_ack = grant_dm;
  assign dm_biu_rsp.ack     = (state == ARB_DATA) & wb_ack;
  assign dm_biu_rsp.err     = (state == ARB_DATA) & wb_err;
  assign dm_biu_rsp.adro    = lat_adr;
  assign dm_biu_rsp.dout    = wb_dat_i;

  // slave answers only inside a cycle, never ack and err together
  a_rsp_in_cyc: assert property (@(posedge clk) disable iff (!rstn)
    done |-> wb_cyc && !(wb_ack && wb_err));

  // slave wait states must not disturb the address
  a_adr_stable: assert property (@(posedge clk) disable iff (!rstn)
    wb_cyc && !done |=> $stable(wb_adr));

endmodule

// File: riscv_dmem_port.sv
`timescale 1ns/1ps
//////////////////////////////
// load/store port
// alignment check, request hold, load data register
//////////////////////////////
module riscv_dmem_port #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic                    clk,
  input  logic                    rstn,

  // data stage side
  input  logic                    mem_req,
  input  logic                    mem_we,
  input  riscv_mem_pkg::size_t    mem_size,
  input  riscv_mem_pkg::addr_t    mem_adr,
  input  riscv_mem_pkg::word_t    mem_d,
  output logic                    mem_rdy,
  output riscv_mem_pkg::word_t    mem_q,
  output logic                    mem_ack,
  output logic                    mem_err,

  // biu side
  output riscv_mem_pkg::biu_req_t dm_biu_req,
  input  riscv_mem_pkg::biu_rsp_t dm_biu_rsp
);
  import riscv_mem_pkg::*;

  localparam int    OFS_BITS = $clog2(XLEN/8);
  localparam addr_t ADR_MASK = addr_t'({PLEN{1'b1}});

  logic  busy;
  logic  req_stb;
  logic  misaligned;
  logic  accept;

  // held request payload
  logic  req_we;
  size_t req_size;
  addr_t req_adr;
  word_t req_dat;

  // half on odd byte, word off the word boundary, unknown size
  always_comb begin
    case (mem_size)
      SIZE_BYTE: misaligned = 1'b0;
      SIZE_HALF: misaligned = mem_adr[0];
      SIZE_WORD: misaligned = |mem_adr[OFS_BITS-1:0];
      default:   misaligned = 1'b1;
    endcase
  end

  assign mem_rdy = ~busy;
  assign accept  = mem_req & mem_rdy;

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy    <= 1'b0;
      req_stb <= 1'b0;
      mem_ack <= 1'b0;
      mem_err <= 1'b0;
    end else begin
      if (accept && !misaligned) begin
        busy    <= 1'b1;
        req_stb <= 1'b1;
      end else begin
        if (dm_biu_rsp.stb_ack) req_stb <= 1'b0;
        if (dm_biu_rsp.ack || dm_biu_rsp.err) busy <= 1'b0;
      end
      mem_ack <= dm_biu_rsp.ack;
      // misaligned access answers without touching the bus
      mem_err <= dm_biu_rsp.err | (accept & misaligned);
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_we   <= mem_we;
      req_size <= mem_size;
      req_adr  <= mem_adr & ADR_MASK;
      req_dat  <= mem_d;
    end
    // loaded bytes moved down to bit 0
    if (dm_biu_rsp.ack && !req_we) begin
      mem_q <= dm_biu_rsp.dout >> {dm_biu_rsp.adro[OFS_BITS-1:0], 3'b000};
    end
  end

  assign dm_biu_req.stb  = req_stb;
  assign dm_biu_req.we   = req_we;
  assign dm_biu_req.adr  = req_adr;
  assign dm_biu_req.size = req_size;
  assign dm_biu_req.di   = req_dat;

  // bus err and local misalign err share mem_err, never with ack
  a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(mem_ack && mem_err));

endmodule

// File: riscv_noicache_core.sv
`timescale 1ns/1ps
//////////////////////////////
// uncached instruction fetch
// word requests toward the biu, 3-entry parcel queue
//////////////////////////////
module riscv_noicache_core #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic                    clk,
  input  logic                    rstn,

  // cpu side
  input  logic                    if_stall,
  input  logic                    if_flush,
  input  riscv_mem_pkg::addr_t    if_nxt_pc,
  output logic                    if_stall_nxt_pc,
  output riscv_mem_pkg::addr_t    if_parcel_pc,
  output riscv_mem_pkg::word_t    if_parcel,
  output logic                    if_parcel_valid,
  output logic                    if_parcel_misaligned,

  // biu side
  output riscv_mem_pkg::biu_req_t if_biu_req,
  input  riscv_mem_pkg::biu_rsp_t if_biu_rsp
);
  import riscv_mem_pkg::*;

  // byte offset bits inside one word
  localparam int    OFS_BITS = $clog2(XLEN/8);
  localparam addr_t ADR_MASK = addr_t'({PLEN{1'b1}});

  // one queue slot, address and data of a parcel
  typedef struct packed {
    addr_t adr;
    word_t dat;
  } parcel_t;

  parcel_t    q_mem [3];
  logic [1:0] q_cnt;
  logic [1:0] wr_idx;

  // requests taken by the biu, not yet answered
  logic [1:0] req_cnt;
  // of those, how many were issued before a flush
  logic [1:0] kill_cnt;

  logic       flush_dly;
  logic       room;
  logic       issue;
  logic       rsp_any;
  logic       push;
  logic       pop;

  //////////////////////////////
  // request side
  //////////////////////////////

  // every queued or outstanding parcel holds one slot
  assign room = ({1'b0, req_cnt} + {1'b0, q_cnt}) < 3'd3;

  assign if_biu_req.stb  = ~if_flush & room;
  assign if_biu_req.we   = 1'b0;
  assign if_biu_req.adr  = if_nxt_pc & ADR_MASK;
  assign if_biu_req.size = SIZE_WORD;
  assign if_biu_req.di   = '0;

  assign issue   = if_biu_req.stb & if_biu_rsp.stb_ack;
  assign rsp_any = if_biu_rsp.ack | if_biu_rsp.err;

  // cpu holds if_nxt_pc until the biu takes it
  assign if_stall_nxt_pc = ~if_biu_rsp.stb_ack | ~room;

  // flush keeps parcels hidden one cycle longer
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush_dly <= 1'b0;
    end else begin
      flush_dly <= if_flush;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      req_cnt <= 2'd0;
    end else begin
      req_cnt <= req_cnt + {1'b0, issue} - {1'b0, rsp_any};
    end
  end

  // everything still on the bus at flush time gets dropped on return
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      kill_cnt <= 2'd0;
    end else if (if_flush) begin
      kill_cnt <= req_cnt - {1'b0, rsp_any};
    end else if (rsp_any && kill_cnt != 2'd0) begin
      kill_cnt <= kill_cnt - 2'd1;
    end
  end

  //////////////////////////////
  // parcel queue
  //////////////////////////////

  // error responses never enter the queue
  assign push = if_biu_rsp.ack & (kill_cnt == 2'd0) & ~if_flush;
  assign pop  = if_parcel_valid;

  // slot 0 is the head, write lands after the survivors
  assign wr_idx = q_cnt - {1'b0, pop};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      q_cnt <= 2'd0;
    end else if (if_flush) begin
      q_cnt <= 2'd0;
    end else begin
      q_cnt <= wr_idx + {1'b0, push};
    end
  end

  // shift on read, the write below wins on the same slot
  always_ff @(posedge clk) begin
    if (pop) begin
      q_mem[0] <= q_mem[1];
      q_mem[1] <= q_mem[2];
    end
    if (push) begin
      q_mem[wr_idx] <= '{adr: if_biu_rsp.adro, dat: if_biu_rsp.dout};
    end
  end

  // to cpu
  assign if_parcel_valid = (q_cnt != 2'd0) & ~if_stall & ~if_flush & ~flush_dly;
  assign if_parcel_pc    = q_mem[0].adr;
  assign if_parcel       = q_mem[0].dat;
  // no compressed parcels, any low bit set is misaligned
  assign if_parcel_misaligned = |q_mem[0].adr[OFS_BITS-1:0];

  // credit count must keep a free slot for every returning parcel
  a_q_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    push |-> wr_idx != 2'd3);

endmodule

// File: riscv_mem_pkg.sv
//////////////////////////////
// memory front end types
// shared by fetch unit, load/store port and wishbone biu
//////////////////////////////
package riscv_mem_pkg;

  //////////////////////////////
  // basic widths
  //////////////////////////////

  // data word, also one instruction parcel
  typedef logic [31:0] word_t;

  // physical address, upper bits zero when PLEN < 32
  typedef logic [31:0] addr_t;

  // transfer size code
  typedef logic [1:0] size_t;

  localparam size_t SIZE_BYTE = 2'b00;
  localparam size_t SIZE_HALF = 2'b01;
  localparam size_t SIZE_WORD = 2'b10;

  //////////////////////////////
  // biu handshake
  //////////////////////////////

  // request from a requester into the biu
  // fields stay stable while stb is high
  typedef struct packed {
    logic  stb;
    logic  we;
    addr_t adr;
    size_t size;
    word_t di;
  } biu_req_t;

  // response from the biu back to one requester
  typedef struct packed {
    // request taken this cycle
    logic  stb_ack;
    // one per data word
    logic  ack;
    logic  err;
    // address belonging to dout
    addr_t adro;
    word_t dout;
  } biu_rsp_t;

  //////////////////////////////
  // arbiter
  //////////////////////////////

  // bus owner of the current wishbone cycle
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH,
    ARB_DATA
  } arb_state_t;

endpackage
